// File: hw/chip_cfg_pkg.sv
package chip_cfg_pkg;

  ////////////////////
  // tag line widths and client ids

  localparam int tag_id_width      = 4;
  localparam int tag_payload_width = 8;
  localparam int dmc_cfg_bytes     = 12;
  localparam int core_ctrl_id      = 0;
  localparam int dmc_cfg_base_id   = 1;
  localparam int core_did_width    = 7;

  localparam int mem_addr_width = 32;
  localparam int mem_data_width = 32;

  typedef enum logic [1:0] {
    tag_idle,
    tag_id,
    tag_payload
  } tag_state_e;

  // one packet off the tag line
  typedef struct packed {
    logic                         valid;
    logic [tag_id_width-1:0]      id;
    logic [tag_payload_width-1:0] payload;
  } tag_msg_s;

  typedef struct packed {
    logic                      reset;
    logic [core_did_width-1:0] did;
  } core_ctrl_s;

  // dram controller timing and mode record
  typedef struct packed {
    logic [15:0] trefi;
    logic [3:0]  tmrd;
    logic [3:0]  trfc;
    logic [3:0]  trc;
    logic [3:0]  trp;
    logic [3:0]  tras;
    logic [3:0]  trrd;
    logic [3:0]  trcd;
    logic [3:0]  twr;
    logic [3:0]  twtr;
    logic [3:0]  trtp;
    logic [3:0]  tcas;
    logic [3:0]  col_width;
    logic [3:0]  row_width;
    logic [1:0]  bank_width;
    logic [5:0]  bank_pos;
    logic [1:0]  dqs_sel_cal;
    logic [3:0]  init_cmd_cnt;
    logic        bypass;
    logic        sys_reset;
  } dmc_cfg_s;

  ////////////////////
  // memory port payloads

  typedef enum logic {
    mem_read,
    mem_write
  } mem_op_e;

  typedef struct packed {
    mem_op_e                   op;
    logic [mem_addr_width-1:0] addr;
    logic [mem_data_width-1:0] data;
  } mem_cmd_s;

  typedef struct packed {
    mem_op_e                   op;
    logic [mem_data_width-1:0] data;
  } mem_resp_s;

endpackage

// File: hw/chip_ctrl_top.sv
`timescale 1ns/10ps

module chip_ctrl_top
#(
  parameter int max_outstanding_p = 4
)
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     tag_data_i,

  input  chip_cfg_pkg::mem_cmd_s   cmd_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  output chip_cfg_pkg::mem_resp_s  resp_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i,

  output chip_cfg_pkg::mem_cmd_s   dmc_cmd_o,
  output logic                     dmc_cmd_v_o,
  input  logic                     dmc_cmd_ready_i,
  input  chip_cfg_pkg::mem_resp_s  dmc_resp_i,
  input  logic                     dmc_resp_v_i,
  output logic                     dmc_resp_ready_o,

  output chip_cfg_pkg::mem_cmd_s   byp_cmd_o,
  output logic                     byp_cmd_v_o,
  input  logic                     byp_cmd_ready_i,
  input  chip_cfg_pkg::mem_resp_s  byp_resp_i,
  input  logic                     byp_resp_v_i,
  output logic                     byp_resp_ready_o,

  output chip_cfg_pkg::core_ctrl_s core_ctrl_o,
  output chip_cfg_pkg::dmc_cfg_s   dmc_cfg_o
);

  chip_cfg_pkg::tag_msg_s tag_msg;

  ////////////////////
  // config path

  tag_master i_tag_master
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tag_data_i (tag_data_i),
    .msg_o      (tag_msg)
  );

  tag_client_bank i_tag_client_bank
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .msg_i       (tag_msg),
    .core_ctrl_o (core_ctrl_o),
    .dmc_cfg_o   (dmc_cfg_o)
  );

  ////////////////////
  // memory steering

  mem_steer #(.max_outstanding_p(max_outstanding_p)) i_mem_steer
  (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .bypass_i         (dmc_cfg_o.bypass),
    .cmd_i            (cmd_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_o           (resp_o),
    .resp_v_o         (resp_v_o),
    .resp_ready_i     (resp_ready_i),
    .dmc_cmd_o        (dmc_cmd_o),
    .dmc_cmd_v_o      (dmc_cmd_v_o),
    .dmc_cmd_ready_i  (dmc_cmd_ready_i),
    .dmc_resp_i       (dmc_resp_i),
    .dmc_resp_v_i     (dmc_resp_v_i),
    .dmc_resp_ready_o (dmc_resp_ready_o),
    .byp_cmd_o        (byp_cmd_o),
    .byp_cmd_v_o      (byp_cmd_v_o),
    .byp_cmd_ready_i  (byp_cmd_ready_i),
    .byp_resp_i       (byp_resp_i),
    .byp_resp_v_i     (byp_resp_v_i),
    .byp_resp_ready_o (byp_resp_ready_o)
  );

endmodule

// File: hw/mem_steer.sv
`timescale 1ns/10ps

module mem_steer
#(
  parameter int max_outstanding_p = 4
)
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    bypass_i,

  input  chip_cfg_pkg::mem_cmd_s  cmd_i,
  input  logic                    cmd_v_i,
  output logic                    cmd_ready_o,
  output chip_cfg_pkg::mem_resp_s resp_o,
  output logic                    resp_v_o,
  input  logic                    resp_ready_i,

  output chip_cfg_pkg::mem_cmd_s  dmc_cmd_o,
  output logic                    dmc_cmd_v_o,
  input  logic                    dmc_cmd_ready_i,
  input  chip_cfg_pkg::mem_resp_s dmc_resp_i,
  input  logic                    dmc_resp_v_i,
  output logic                    dmc_resp_ready_o,

  output chip_cfg_pkg::mem_cmd_s  byp_cmd_o,
  output logic                    byp_cmd_v_o,
  input  logic                    byp_cmd_ready_i,
  input  chip_cfg_pkg::mem_resp_s byp_resp_i,
  input  logic                    byp_resp_v_i,
  output logic                    byp_resp_ready_o
);

  localparam int cnt_width = $clog2(max_outstanding_p + 1);

  logic                 sel_r;
  logic                 sel;
  logic [cnt_width-1:0] count_r;
  logic                 idle;
  logic                 full;
  logic                 pending;
  logic                 stall;
  logic                 cmd_xfer;
  logic                 resp_xfer;

  ////////////////////
  // selection and stall

  assign idle    = (count_r == '0);
  assign full    = (count_r == cnt_width'(max_outstanding_p));
  assign pending = (bypass_i != sel_r) && !idle;
  assign stall   = full || pending;

  // with nothing in flight the bypass bit takes effect at once
  assign sel = idle ? bypass_i : sel_r;

  ////////////////////
  // port routing

  always_comb
  begin
    dmc_cmd_o        = '0;
    dmc_cmd_v_o      = 1'b0;
    dmc_resp_ready_o = 1'b1;
    byp_cmd_o        = '0;
    byp_cmd_v_o      = 1'b0;
    byp_resp_ready_o = 1'b1;
    if (sel)
    begin
      byp_cmd_o        = cmd_i;
      byp_cmd_v_o      = cmd_v_i && !stall;
      cmd_ready_o      = byp_cmd_ready_i && !stall;
      resp_o           = byp_resp_i;
      resp_v_o         = byp_resp_v_i;
      byp_resp_ready_o = resp_ready_i;
    end
    else
    begin
      dmc_cmd_o        = cmd_i;
      dmc_cmd_v_o      = cmd_v_i && !stall;
      cmd_ready_o      = dmc_cmd_ready_i && !stall;
      resp_o           = dmc_resp_i;
      resp_v_o         = dmc_resp_v_i;
      dmc_resp_ready_o = resp_ready_i;
    end
  end

  assign cmd_xfer  = cmd_v_i && cmd_ready_o;
  assign resp_xfer = resp_v_o && resp_ready_i;

  ////////////////////
  // outstanding count

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      sel_r   <= 1'b0;
      count_r <= '0;
    end
    else
    begin
      sel_r   <= sel;
      count_r <= count_r + cnt_width'(cmd_xfer) - cnt_width'(resp_xfer);
    end
  end

endmodule

// File: hw/tag_client_bank.sv
`timescale 1ns/10ps

module tag_client_bank
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  chip_cfg_pkg::tag_msg_s   msg_i,
  output chip_cfg_pkg::core_ctrl_s core_ctrl_o,
  output chip_cfg_pkg::dmc_cfg_s   dmc_cfg_o
);

  localparam int num_clients = chip_cfg_pkg::dmc_cfg_bytes + 1;

  logic [num_clients-1:0][chip_cfg_pkg::tag_payload_width-1:0]                regs_r;
  logic [chip_cfg_pkg::dmc_cfg_bytes-1:0][chip_cfg_pkg::tag_payload_width-1:0] cfg_bytes;

  logic id_in_range;

  // ids past the last config byte have no client
  assign id_in_range = (msg_i.id < num_clients);

  ////////////////////
  // client registers

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      regs_r <= '0;
    end
    else if (msg_i.valid && id_in_range)
    begin
      regs_r[msg_i.id] <= msg_i.payload;
    end
  end

  assign core_ctrl_o = chip_cfg_pkg::core_ctrl_s'(regs_r[chip_cfg_pkg::core_ctrl_id]);

  assign cfg_bytes = regs_r[chip_cfg_pkg::dmc_cfg_base_id +: chip_cfg_pkg::dmc_cfg_bytes];

  ////////////////////
  // dram config decode

  assign dmc_cfg_o.trefi        = {cfg_bytes[1], cfg_bytes[0]};
  assign dmc_cfg_o.tmrd         = cfg_bytes[2][3:0];
  assign dmc_cfg_o.trfc         = cfg_bytes[2][7:4];
  assign dmc_cfg_o.trc          = cfg_bytes[3][3:0];
  assign dmc_cfg_o.trp          = cfg_bytes[3][7:4];
  assign dmc_cfg_o.tras         = cfg_bytes[4][3:0];
  assign dmc_cfg_o.trrd         = cfg_bytes[4][7:4];
  assign dmc_cfg_o.trcd         = cfg_bytes[5][3:0];
  assign dmc_cfg_o.twr          = cfg_bytes[5][7:4];
  assign dmc_cfg_o.twtr         = cfg_bytes[6][3:0];
  assign dmc_cfg_o.trtp         = cfg_bytes[6][7:4];
  assign dmc_cfg_o.tcas         = cfg_bytes[7][3:0];
  assign dmc_cfg_o.col_width    = cfg_bytes[8][3:0];
  assign dmc_cfg_o.row_width    = cfg_bytes[8][7:4];
  assign dmc_cfg_o.bank_width   = cfg_bytes[9][1:0];
  assign dmc_cfg_o.bank_pos     = cfg_bytes[9][7:2];
  assign dmc_cfg_o.dqs_sel_cal  = cfg_bytes[10][1:0];
  assign dmc_cfg_o.init_cmd_cnt = cfg_bytes[10][5:2];

  // byte 10 bit 7 and byte 11 bits 7:1 are spare
  assign dmc_cfg_o.bypass       = cfg_bytes[10][6];
  assign dmc_cfg_o.sys_reset    = cfg_bytes[11][0];

endmodule

// File: hw/tag_master.sv
`timescale 1ns/10ps

module tag_master
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    tag_data_i,
  output chip_cfg_pkg::tag_msg_s  msg_o
);

  localparam int cnt_width = $clog2(chip_cfg_pkg::tag_payload_width);
  localparam int pkt_width = chip_cfg_pkg::tag_id_width + chip_cfg_pkg::tag_payload_width;

  chip_cfg_pkg::tag_state_e state_r;
  logic [cnt_width-1:0]     cnt_r;
  logic                     msg_v_r;
  logic [pkt_width-1:0]     shift_r;

  logic id_last;
  logic payload_last;

  assign id_last      = (cnt_r == cnt_width'(chip_cfg_pkg::tag_id_width - 1));
  assign payload_last = (cnt_r == cnt_width'(chip_cfg_pkg::tag_payload_width - 1));

  ////////////////////
  // packet FSM

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= chip_cfg_pkg::tag_idle;
      cnt_r   <= '0;
      msg_v_r <= 1'b0;
    end
    else
    begin
      msg_v_r <= 1'b0;
      case (state_r)
        chip_cfg_pkg::tag_idle:
        begin
          // a high sample here is the start bit
          if (tag_data_i)
          begin
            state_r <= chip_cfg_pkg::tag_id;
            cnt_r   <= '0;
          end
        end
        chip_cfg_pkg::tag_id:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (id_last)
          begin
            state_r <= chip_cfg_pkg::tag_payload;
            cnt_r   <= '0;
          end
        end
        chip_cfg_pkg::tag_payload:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (payload_last)
          begin
            // back in idle while the strobe is up
            state_r <= chip_cfg_pkg::tag_idle;
            cnt_r   <= '0;
            msg_v_r <= 1'b1;
          end
        end
        default:
        begin
          state_r <= chip_cfg_pkg::tag_idle;
          cnt_r   <= '0;
        end
      endcase
    end
  end

  // id then payload, msb first
  always_ff @(posedge clk_i)
  begin
    if (state_r != chip_cfg_pkg::tag_idle)
    begin
      shift_r <= {shift_r[pkt_width-2:0], tag_data_i};
    end
  end

  assign msg_o.valid   = msg_v_r;
  assign msg_o.id      = shift_r[pkt_width-1 -: chip_cfg_pkg::tag_id_width];
  assign msg_o.payload = shift_r[chip_cfg_pkg::tag_payload_width-1:0];

endmodule

// File: list.f
+incdir+test
hw/chip_cfg_pkg.sv
hw/tag_master.sv
hw/tag_client_bank.sv
hw/mem_steer.sv
hw/chip_ctrl_top.sv
test/tb_chip_ctrl.sv

// File: test/tb_chip_ctrl_util.svh
////////////////////
// random source

// taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
  int i;
  v = '0;
  for (i = 0; i < n; i++)
  begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[30:0], lfsr_q[0]};
  end
endtask

////////////////////
// expected values

function automatic chip_cfg_pkg::dmc_cfg_s ref_dmc_cfg(input cfg_bytes_t b);
  chip_cfg_pkg::dmc_cfg_s c;
  c.trefi        = {b[1], b[0]};
  c.tmrd         = b[2][3:0];
  c.trfc         = b[2][7:4];
  c.trc          = b[3][3:0];
  c.trp          = b[3][7:4];
  c.tras         = b[4][3:0];
  c.trrd         = b[4][7:4];
  c.trcd         = b[5][3:0];
  c.twr          = b[5][7:4];
  c.twtr         = b[6][3:0];
  c.trtp         = b[6][7:4];
  c.tcas         = b[7][3:0];
  c.col_width    = b[8][3:0];
  c.row_width    = b[8][7:4];
  c.bank_width   = b[9][1:0];
  c.bank_pos     = b[9][7:2];
  c.dqs_sel_cal  = b[10][1:0];
  c.init_cmd_cnt = b[10][5:2];
  c.bypass       = b[10][6];
  c.sys_reset    = b[11][0];
  ref_dmc_cfg    = c;
endfunction

// reset in the top bit, did below it
function automatic chip_cfg_pkg::core_ctrl_s ref_core_ctrl(input logic [7:0] p);
  chip_cfg_pkg::core_ctrl_s c;
  c.reset       = p[7];
  c.did         = p[6:0];
  ref_core_ctrl = c;
endfunction

function automatic chip_cfg_pkg::mem_resp_s ref_resp(input chip_cfg_pkg::mem_cmd_s c,
                                                     input logic to_byp);
  chip_cfg_pkg::mem_resp_s r;
  r.op = c.op;
  if (c.op == chip_cfg_pkg::mem_read)
  begin
    r.data = c.addr ^ (to_byp ? byp_key : dmc_key);
  end
  else
  begin
    r.data = c.data;
  end
  ref_resp = r;
endfunction

////////////////////
// compares

task automatic check_dmc_cfg(input chip_cfg_pkg::dmc_cfg_s got,
                             input chip_cfg_pkg::dmc_cfg_s want, input string what);
  if (got !== want)
  begin
    abort_run($sformatf("mismatch at %0t: %s, dmc_cfg_o %h, expected %h",
                        $time, what, got, want));
  end
endtask

task automatic check_core_ctrl(input chip_cfg_pkg::core_ctrl_s got,
                               input chip_cfg_pkg::core_ctrl_s want, input string what);
  if (got !== want)
  begin
    abort_run($sformatf("mismatch at %0t: %s, core_ctrl_o %h, expected %h",
                        $time, what, got, want));
  end
endtask

task automatic check_resp(input chip_cfg_pkg::mem_resp_s got,
                          input chip_cfg_pkg::mem_resp_s want, input string what);
  if (got !== want)
  begin
    abort_run($sformatf("mismatch at %0t: %s, resp_o %h, expected %h",
                        $time, what, got, want));
  end
endtask

task automatic check_cmd(input chip_cfg_pkg::mem_cmd_s got,
                         input chip_cfg_pkg::mem_cmd_s want, input string what);
  if (got !== want)
  begin
    abort_run($sformatf("mismatch at %0t: %s, command %h, expected %h",
                        $time, what, got, want));
  end
endtask

// File: test/tb_chip_ctrl.sv
`timescale 1ns/10ps

// memory that answers in order, reads give addr xor key
module mem_model
#(
  parameter logic [31:0] key_p = 32'h0
)
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    hold_i,
  input  chip_cfg_pkg::mem_cmd_s  cmd_i,
  input  logic                    cmd_v_i,
  output logic                    cmd_ready_o,
  output chip_cfg_pkg::mem_resp_s resp_o,
  output logic                    resp_v_o,
  input  logic                    resp_ready_i
);

  chip_cfg_pkg::mem_resp_s pend_q[$];

  assign cmd_ready_o = 1'b1;

  initial
  begin
    resp_o   = '0;
    resp_v_o = 1'b0;
  end

  always @(posedge clk_i)
  begin : serve
    chip_cfg_pkg::mem_resp_s r;
    chip_cfg_pkg::mem_resp_s gone;
    if (rst_i)
    begin
      pend_q.delete();
      resp_v_o <= 1'b0;
    end
    else
    begin
      if (resp_v_o && resp_ready_i)
      begin
        gone = pend_q.pop_front();
      end
      if (cmd_v_i && cmd_ready_o)
      begin
        r.op   = cmd_i.op;
        r.data = (cmd_i.op == chip_cfg_pkg::mem_read) ? (cmd_i.addr ^ key_p) : cmd_i.data;
        pend_q.push_back(r);
      end
      resp_v_o <= (pend_q.size() != 0) && !hold_i;
      if (pend_q.size() != 0)
      begin
        resp_o <= pend_q[0];
      end
    end
  end

endmodule

module tb_chip_ctrl;

  localparam int max_out        = 4;
  localparam int n_rand_cmds    = 8;
  localparam int n_packets      = chip_cfg_pkg::dmc_cfg_bytes + 7;
  localparam int n_cmds         = n_rand_cmds + 6 + max_out + 1;
  localparam int timeout_cycles = n_packets * 20 + n_cmds * 40 + 200;

  localparam logic [31:0] dmc_key = 32'h5a5a0f0f;
  localparam logic [31:0] byp_key = 32'hc3a53c96;

  typedef logic [chip_cfg_pkg::tag_id_width-1:0] tag_id_t;
  typedef logic [chip_cfg_pkg::dmc_cfg_bytes-1:0][chip_cfg_pkg::tag_payload_width-1:0]
    cfg_bytes_t;

  logic                     clk_i;
  logic                     rst_i;
  logic                     tag_data_i;
  chip_cfg_pkg::mem_cmd_s   cmd_i;
  logic                     cmd_v_i;
  logic                     cmd_ready_o;
  chip_cfg_pkg::mem_resp_s  resp_o;
  logic                     resp_v_o;
  logic                     resp_ready_i;
  chip_cfg_pkg::mem_cmd_s   dmc_cmd_o;
  logic                     dmc_cmd_v_o;
  logic                     dmc_cmd_ready_i;
  chip_cfg_pkg::mem_resp_s  dmc_resp_i;
  logic                     dmc_resp_v_i;
  logic                     dmc_resp_ready_o;
  chip_cfg_pkg::mem_cmd_s   byp_cmd_o;
  logic                     byp_cmd_v_o;
  logic                     byp_cmd_ready_i;
  chip_cfg_pkg::mem_resp_s  byp_resp_i;
  logic                     byp_resp_v_i;
  logic                     byp_resp_ready_o;
  chip_cfg_pkg::core_ctrl_s core_ctrl_o;
  chip_cfg_pkg::dmc_cfg_s   dmc_cfg_o;

  logic [31:0]             lfsr_q;
  cfg_bytes_t              cfg_bytes;
  logic [7:0]              core_byte;
  logic                    hold_dmc;
  logic                    route_byp;
  chip_cfg_pkg::mem_resp_s exp_q[$];
  int                      resp_seen;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  `include "tb_chip_ctrl_util.svh"

  chip_ctrl_top #(.max_outstanding_p(max_out)) i_dut (.*);

  mem_model #(.key_p(dmc_key)) i_dmc_mem
  (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hold_i       (hold_dmc),
    .cmd_i        (dmc_cmd_o),
    .cmd_v_i      (dmc_cmd_v_o),
    .cmd_ready_o  (dmc_cmd_ready_i),
    .resp_o       (dmc_resp_i),
    .resp_v_o     (dmc_resp_v_i),
    .resp_ready_i (dmc_resp_ready_o)
  );

  mem_model #(.key_p(byp_key)) i_byp_mem
  (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hold_i       (1'b0),
    .cmd_i        (byp_cmd_o),
    .cmd_v_i      (byp_cmd_v_o),
    .cmd_ready_o  (byp_cmd_ready_i),
    .resp_o       (byp_resp_i),
    .resp_v_o     (byp_resp_v_i),
    .resp_ready_i (byp_resp_ready_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial
  begin : watchdog
    repeat (timeout_cycles) @(posedge clk_i);
    abort_run("timeout: the tests did not finish within the expected number of cycles");
  end

  ////////////////////
  // checking processes

  always @(posedge clk_i)
  begin : compare
    chip_cfg_pkg::mem_resp_s want;
    if (!rst_i && resp_v_o && resp_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        abort_run("a response came back while no command was outstanding");
      end
      else
      begin
        want = exp_q.pop_front();
        check_resp(resp_o, want, "upstream response");
        resp_seen++;
      end
    end
  end

  always @(posedge clk_i)
  begin : routing
    if (!rst_i && dmc_cmd_v_o)
    begin
      if (route_byp)
        abort_run("a command reached the dmc port while the bypass port was selected");
      else
        check_cmd(dmc_cmd_o, cmd_i, "dmc command");
    end
    if (!rst_i && byp_cmd_v_o)
    begin
      if (!route_byp)
        abort_run("a command reached the bypass port while the dmc port was selected");
      else
        check_cmd(byp_cmd_o, cmd_i, "bypass command");
    end
    // the idle port always drains its responses
    if (!rst_i && (route_byp ? dmc_resp_ready_o : byp_resp_ready_o) !== 1'b1)
      abort_run("the response ready of the unselected port was not high");
  end

  ////////////////////
  // stimulus tasks

  // start bit, id and payload, msb first
  task automatic send_packet(input tag_id_t id, input logic [7:0] payload);
    logic [11:0] bits;
    int          i;
    bits = {id, payload};
    @(posedge clk_i);
    tag_data_i <= 1'b1;
    for (i = 11; i >= 0; i--)
    begin
      @(posedge clk_i);
      tag_data_i <= bits[i];
    end
    @(posedge clk_i);
    tag_data_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  // config byte 10 bit 6 is the bypass bit
  task automatic set_bypass(input logic b);
    cfg_bytes[10][6] = b;
    send_packet(tag_id_t'(chip_cfg_pkg::dmc_cfg_base_id + 10), cfg_bytes[10]);
    check_dmc_cfg(dmc_cfg_o, ref_dmc_cfg(cfg_bytes), "bypass write");
  endtask

  task automatic random_cmd(output chip_cfg_pkg::mem_cmd_s c);
    logic [31:0] v;
    take_bits(1, v);
    c.op = chip_cfg_pkg::mem_op_e'(v[0]);
    take_bits(32, v);
    c.addr = v;
    take_bits(32, v);
    c.data = v;
  endtask

  task automatic drive_cmd(input chip_cfg_pkg::mem_cmd_s c);
    @(posedge clk_i);
    cmd_i   <= c;
    cmd_v_i <= 1'b1;
  endtask

  task automatic finish_cmd(input logic to_byp);
    @(posedge clk_i);
    while (!cmd_ready_o)
    begin
      @(posedge clk_i);
    end
    exp_q.push_back(ref_resp(cmd_i, to_byp));
    cmd_v_i <= 1'b0;
  endtask

  task automatic issue_cmd(input logic to_byp);
    chip_cfg_pkg::mem_cmd_s c;
    random_cmd(c);
    drive_cmd(c);
    finish_cmd(to_byp);
  endtask

  task automatic expect_stall(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      if (cmd_ready_o)
        abort_run("cmd_ready_o was high while new commands should have stalled");
    end
  endtask

  task automatic drain;
    while (exp_q.size() != 0)
    begin
      @(posedge clk_i);
    end
  endtask

  ////////////////////
  // test sequence

  initial
  begin : stimulus
    logic [31:0]            v;
    int                     i;
    int                     seen;
    chip_cfg_pkg::mem_cmd_s c;
    rst_i        = 1'b1;
    tag_data_i   = 1'b0;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    hold_dmc     = 1'b0;
    route_byp    = 1'b0;
    lfsr_q       = 32'h8a826ebf;
    cfg_bytes    = '0;
    core_byte    = '0;
    resp_seen    = 0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    check_dmc_cfg(dmc_cfg_o, ref_dmc_cfg(cfg_bytes), "config after reset");
    check_core_ctrl(core_ctrl_o, ref_core_ctrl(core_byte), "core control after reset");

    // all twelve config bytes
    for (i = 0; i < chip_cfg_pkg::dmc_cfg_bytes; i++)
    begin
      take_bits(8, v);
      cfg_bytes[i] = v[7:0];
      send_packet(tag_id_t'(chip_cfg_pkg::dmc_cfg_base_id + i), v[7:0]);
      check_dmc_cfg(dmc_cfg_o, ref_dmc_cfg(cfg_bytes), "config byte write");
    end

    take_bits(8, v);
    core_byte = v[7:0];
    send_packet(tag_id_t'(chip_cfg_pkg::core_ctrl_id), core_byte);
    check_core_ctrl(core_ctrl_o, ref_core_ctrl(core_byte), "core control write");
    check_dmc_cfg(dmc_cfg_o, ref_dmc_cfg(cfg_bytes), "config after core control write");

    // ids with no client
    for (i = 13; i < 16; i++)
    begin
      take_bits(8, v);
      send_packet(tag_id_t'(i), v[7:0]);
      check_core_ctrl(core_ctrl_o, ref_core_ctrl(core_byte), "core control after unused id");
      check_dmc_cfg(dmc_cfg_o, ref_dmc_cfg(cfg_bytes), "config after unused id");
    end

    set_bypass(1'b0);
    resp_ready_i <= 1'b0;
    for (i = 0; i < n_rand_cmds; i++)
    begin
      // upstream holds off the first two responses
      if (i == 2)
        resp_ready_i <= 1'b1;
      issue_cmd(1'b0);
    end
    drain();

    // switch to bypass with dmc responses in flight
    hold_dmc <= 1'b1;
    issue_cmd(1'b0);
    issue_cmd(1'b0);
    set_bypass(1'b1);
    seen = resp_seen;
    route_byp <= 1'b1;
    random_cmd(c);
    drive_cmd(c);
    expect_stall(4);
    hold_dmc <= 1'b0;
    finish_cmd(1'b1);
    if (resp_seen != seen + 2)
      abort_run("a bypass command was accepted before the dmc responses completed");
    issue_cmd(1'b1);
    drain();
    set_bypass(1'b0);
    route_byp <= 1'b0;
    issue_cmd(1'b0);
    issue_cmd(1'b0);
    drain();

    // outstanding limit
    hold_dmc <= 1'b1;
    for (i = 0; i < max_out; i++)
    begin
      issue_cmd(1'b0);
    end
    random_cmd(c);
    drive_cmd(c);
    expect_stall(4);
    seen = resp_seen;
    hold_dmc <= 1'b0;
    @(posedge clk_i);
    hold_dmc <= 1'b1;
    finish_cmd(1'b0);
    if (resp_seen != seen + 1)
      abort_run("cmd_ready_o rose without exactly one response transfer");
    hold_dmc <= 1'b0;
    drain();

    $display("TEST OK");
    $finish;
  end

endmodule
